// ==== btnPkg.sv ====
package btnPkg;

    // ******************************
    // button and bus types
    // ******************************

    // one bit per button, down is the msb
    typedef struct packed {
        logic down;
        logic up;
        logic left;
        logic right;
    } btnVec_t;

    // plain strobe bus from the host
    typedef struct packed {
        logic        ren;
        logic        wen;
        logic [3:0]  addr;
        logic [31:0] wdata;
    } busReq_t;

    // register map, everything above addrIrqEn is unmapped
    typedef enum logic [3:0] {
        addrStatus   = 4'h0,  // debounced levels
        addrPressed  = 4'h1,  // sticky press flags, w1c
        addrReleased = 4'h2,  // sticky release flags, w1c
        addrIrqEn    = 4'h3   // per button irq enable
    } regAddr_e;

    typedef enum logic [0:0] {
        stIdle     = 1'b0,
        stCounting = 1'b1
    } debState_e;

    // ******************************
    // timing
    // ******************************

    // steady cycles before the stable level follows, small for sim
    localparam int debounceCycles = 16;

    localparam int syncDepth = 2;  // synchronizer flops

    localparam logic [31:0] unmappedValue = 32'hFFFF_FFFF;

endpackage

// ==== btnDebounce.sv ====
`timescale 1ns/1ps

module btnDebounce (
    input  logic clk,
    input  logic rstN,
    input  logic btnIn,
    output logic btnStable
);

    // ******************************
    // synchronizer
    // ******************************

    logic [btnPkg::syncDepth-1:0] syncReg;
    logic                         syncIn;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            syncReg <= '0;
        end else begin
            syncReg <= {syncReg[btnPkg::syncDepth-2:0], btnIn};
        end
    end

    assign syncIn = syncReg[btnPkg::syncDepth-1];

    // ******************************
    // debounce fsm
    // ******************************

    btnPkg::debState_e state;
    btnPkg::debState_e nextState;

    logic [$clog2(btnPkg::debounceCycles)-1:0] count;

    logic differs;    // sync input away from stable level
    logic countDone;
    logic countInc;
    logic takeLevel;

    assign differs   = (syncIn != btnStable);
    assign countDone = (int'(count) == btnPkg::debounceCycles - 1);

    always_comb begin
        nextState = state;
        countInc  = 1'b0;
        takeLevel = 1'b0;
        case (state)
            btnPkg::stIdle: begin
                if (differs) begin
                    nextState = btnPkg::stCounting;
                    countInc  = 1'b1;
                end
            end
            btnPkg::stCounting: begin
                if (!differs) begin
                    nextState = btnPkg::stIdle;  // bounce, restart the wait
                end else if (countDone) begin
                    nextState = btnPkg::stIdle;
                    takeLevel = 1'b1;
                end else begin
                    countInc = 1'b1;
                end
            end
            default: begin
                nextState = btnPkg::stIdle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= btnPkg::stIdle;
        end else begin
            state <= nextState;
        end
    end

    // counter only runs while the difference holds
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (countInc) begin
            count <= count + 1'b1;
        end else begin
            count <= '0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            btnStable <= 1'b0;
        end else if (takeLevel) begin
            btnStable <= syncIn;
        end
    end

endmodule

// ==== btnEventLatch.sv ====
`timescale 1ns/1ps

module btnEventLatch (
    input  logic            clk,
    input  logic            rstN,
    input  btnPkg::btnVec_t stable,
    input  btnPkg::btnVec_t clrPressed,
    input  btnPkg::btnVec_t clrReleased,
    output btnPkg::btnVec_t pressedFlags,
    output btnPkg::btnVec_t releasedFlags
);

    // ******************************
    // edge detect
    // ******************************

    btnPkg::btnVec_t prevStable;
    btnPkg::btnVec_t riseEdge;
    btnPkg::btnVec_t fallEdge;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            prevStable <= '0;  // matches stable level out of reset
        end else begin
            prevStable <= stable;
        end
    end

    assign riseEdge = btnPkg::btnVec_t'(stable & ~prevStable);
    assign fallEdge = btnPkg::btnVec_t'(~stable & prevStable);

    // ******************************
    // sticky flags
    // ******************************

    btnPkg::btnVec_t pressedNext;
    btnPkg::btnVec_t releasedNext;

    // set wins over a clear in the same cycle
    always_comb begin
        pressedNext  = btnPkg::btnVec_t'((pressedFlags & ~clrPressed) | riseEdge);
        releasedNext = btnPkg::btnVec_t'((releasedFlags & ~clrReleased) | fallEdge);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pressedFlags  <= '0;
            releasedFlags <= '0;
        end else begin
            pressedFlags  <= pressedNext;
            releasedFlags <= releasedNext;
        end
    end

endmodule

// ==== btnRegFile.sv ====
`timescale 1ns/1ps

module btnRegFile (
    input  logic            clk,
    input  logic            rstN,
    input  btnPkg::busReq_t busReq,
    input  btnPkg::btnVec_t stable,
    input  btnPkg::btnVec_t pressedFlags,
    input  btnPkg::btnVec_t releasedFlags,
    output btnPkg::btnVec_t clrPressed,
    output btnPkg::btnVec_t clrReleased,
    output logic [31:0]     rdata,
    output logic            irq
);

    // ******************************
    // address decode
    // ******************************

    btnPkg::regAddr_e regAddr;

    logic wrPressed;
    logic wrReleased;
    logic wrIrqEn;

    assign regAddr = btnPkg::regAddr_e'(busReq.addr);

    assign wrPressed  = busReq.wen && (regAddr == btnPkg::addrPressed);
    assign wrReleased = busReq.wen && (regAddr == btnPkg::addrReleased);
    assign wrIrqEn    = busReq.wen && (regAddr == btnPkg::addrIrqEn);

    // w1c masks, one cycle wide
    assign clrPressed  = wrPressed  ? btnPkg::btnVec_t'(busReq.wdata[3:0]) : '0;
    assign clrReleased = wrReleased ? btnPkg::btnVec_t'(busReq.wdata[3:0]) : '0;

    // ******************************
    // irq enable
    // ******************************

    btnPkg::btnVec_t irqEn;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            irqEn <= '0;
        end else if (wrIrqEn) begin
            irqEn <= btnPkg::btnVec_t'(busReq.wdata[3:0]);
        end
    end

    // ******************************
    // read mux
    // ******************************

    logic [31:0] readValue;

    always_comb begin
        case (regAddr)
            btnPkg::addrStatus:   readValue = {28'd0, stable};
            btnPkg::addrPressed:  readValue = {28'd0, pressedFlags};
            btnPkg::addrReleased: readValue = {28'd0, releasedFlags};
            btnPkg::addrIrqEn:    readValue = {28'd0, irqEn};
            default:              readValue = btnPkg::unmappedValue;
        endcase
    end

    // holds between reads
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdata <= '0;
        end else if (busReq.ren) begin
            rdata <= readValue;
        end
    end

    // level interrupt, any enabled press pending
    logic irqNext;

    assign irqNext = |(pressedFlags & irqEn);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            irq <= 1'b0;
        end else begin
            irq <= irqNext;
        end
    end

endmodule

// ==== btnPeripheral.sv ====
`timescale 1ns/1ps

module btnPeripheral (
    input  logic            clk,
    input  logic            rstN,
    input  btnPkg::btnVec_t btnRaw,
    input  btnPkg::busReq_t busReq,
    output logic [31:0]     rdata,
    output logic            irq
);

    wire btnPkg::btnVec_t stable;  // one bit per debouncer
    btnPkg::btnVec_t      pressedFlags;
    btnPkg::btnVec_t      releasedFlags;
    btnPkg::btnVec_t      clrPressed;
    btnPkg::btnVec_t      clrReleased;

    // ******************************
    // debouncers
    // ******************************

    btnDebounce debDown (
        .clk       (clk),
        .rstN      (rstN),
        .btnIn     (btnRaw.down),
        .btnStable (stable.down)
    );

    btnDebounce debUp (
        .clk       (clk),
        .rstN      (rstN),
        .btnIn     (btnRaw.up),
        .btnStable (stable.up)
    );

    btnDebounce debLeft (
        .clk       (clk),
        .rstN      (rstN),
        .btnIn     (btnRaw.left),
        .btnStable (stable.left)
    );

    btnDebounce debRight (
        .clk       (clk),
        .rstN      (rstN),
        .btnIn     (btnRaw.right),
        .btnStable (stable.right)
    );

    btnEventLatch eventLatch (
        .clk           (clk),
        .rstN          (rstN),
        .stable        (stable),
        .clrPressed    (clrPressed),
        .clrReleased   (clrReleased),
        .pressedFlags  (pressedFlags),
        .releasedFlags (releasedFlags)
    );

    btnRegFile regFile (
        .clk           (clk),
        .rstN          (rstN),
        .busReq        (busReq),
        .stable        (stable),
        .pressedFlags  (pressedFlags),
        .releasedFlags (releasedFlags),
        .clrPressed    (clrPressed),
        .clrReleased   (clrReleased),
        .rdata         (rdata),
        .irq           (irq)
    );

endmodule

// ==== btnPeripheralChecker.sv ====
`timescale 1ns/1ps

module btnPeripheralChecker (
    input  logic            clk,
    input  logic            rstN,
    input  btnPkg::btnVec_t btnRaw,
    input  btnPkg::busReq_t busReq,
    input  logic [31:0]     rdata,
    input  logic            irq,
    output int              errorCount
);

    // ******************************
    // reference model state
    // ******************************

    logic [3:0]  syncPipe [btnPkg::syncDepth];  // index 0 nearest the pin
    logic [3:0]  mStable;
    logic [3:0]  mPrev;
    logic [3:0]  mPressed;
    logic [3:0]  mReleased;
    logic [3:0]  mEn;
    logic        mIrq;
    logic [31:0] expRdata;
    logic        modelLive;
    int          mCount [4];
    int          errors = 0;

    assign errorCount = errors;

    function automatic logic [31:0] modelRead(input logic [3:0] addr);
        case (addr)
            btnPkg::addrStatus:   return {28'd0, mStable};
            btnPkg::addrPressed:  return {28'd0, mPressed};
            btnPkg::addrReleased: return {28'd0, mReleased};
            btnPkg::addrIrqEn:    return {28'd0, mEn};
            default:              return 32'hFFFF_FFFF;
        endcase
    endfunction

    always @(posedge clk or negedge rstN) begin : model
        logic [3:0] clrP;
        logic [3:0] clrR;
        logic [3:0] nextPressed;
        logic [3:0] nextReleased;
        logic [3:0] syncOut;
        if (!rstN) begin
            for (int s = 0; s < btnPkg::syncDepth; s++) syncPipe[s] = 4'h0;
            for (int i = 0; i < 4; i++) mCount[i] = 0;
            mStable     = 4'h0;
            mPrev       = 4'h0;
            mPressed    = 4'h0;
            mReleased   = 4'h0;
            mEn         = 4'h0;
            mIrq        = 1'b0;
            expRdata    = 32'h0;
            modelLive   = 1'b0;
        end else begin
            modelLive = 1'b1;
            syncOut   = syncPipe[btnPkg::syncDepth-1];
            clrP = (busReq.wen && busReq.addr == btnPkg::addrPressed) ? busReq.wdata[3:0] : 4'h0;
            clrR = (busReq.wen && busReq.addr == btnPkg::addrReleased) ? busReq.wdata[3:0] : 4'h0;
            if (busReq.ren) expRdata = modelRead(busReq.addr);
            mIrq = |(mPressed & mEn);
            nextPressed  = (mPressed & ~clrP) | (mStable & ~mPrev);   // set beats clear
            nextReleased = (mReleased & ~clrR) | (~mStable & mPrev);
            mPrev = mStable;
            for (int i = 0; i < 4; i++) begin
                if (syncOut[i] == mStable[i]) begin
                    mCount[i] = 0;  // steady or bounced back
                end else if (mCount[i] == btnPkg::debounceCycles - 1) begin
                    mStable[i] = syncOut[i];
                    mCount[i]  = 0;
                end else begin
                    mCount[i]++;
                end
            end
            for (int s = btnPkg::syncDepth - 1; s > 0; s--) syncPipe[s] = syncPipe[s-1];
            syncPipe[0] = btnRaw;
            if (busReq.wen && busReq.addr == btnPkg::addrIrqEn) mEn = busReq.wdata[3:0];
            mPressed  = nextPressed;
            mReleased = nextReleased;
        end
    end

    // outputs settled mid cycle
    always @(negedge clk) begin
        if (modelLive) begin
            if (rdata !== expRdata) begin  // also covers holds between reads
                errors++;
                $display("** Error: rdata = %h, expected %h at %0t", rdata, expRdata, $time);
            end
            if (irq !== mIrq) begin
                errors++;
                $display("** Error: irq = %h, expected %h at %0t", irq, mIrq, $time);
            end
        end
    end

endmodule

// ==== btnPeripheral_asserts.sv ====
`timescale 1ns/1ps

module btnPeripheralAsserts (
    input logic            clk,
    input logic            rstN,
    input btnPkg::busReq_t busReq,
    input btnPkg::btnVec_t pressedFlags,
    input btnPkg::btnVec_t irqEn,
    input btnPkg::btnVec_t clrPressed,
    input btnPkg::btnVec_t clrReleased,
    input logic [31:0]     rdata,
    input logic            irq
);

    // rdata only moves on an edge that sampled ren
    rdataHolds: assert property (@(posedge clk) disable iff (!rstN)
        !$past(busReq.ren) |-> $stable(rdata))
        else $error("rdata changed without a read in the previous cycle");

    irqHasCause: assert property (@(posedge clk) disable iff (!rstN)
        irq |-> $past(|(pressedFlags & irqEn)))
        else $error("irq high with no enabled press flag behind it");

    clearNeedsWrite: assert property (@(posedge clk) disable iff (!rstN)
        !busReq.wen |-> (clrPressed == '0) && (clrReleased == '0))
        else $error("clear mask active while wen is low");

endmodule

bind btnRegFile btnPeripheralAsserts u_asserts (
    .clk          (clk),
    .rstN         (rstN),
    .busReq       (busReq),
    .pressedFlags (pressedFlags),
    .irqEn        (irqEn),
    .clrPressed   (clrPressed),
    .clrReleased  (clrReleased),
    .rdata        (rdata),
    .irq          (irq)
);

// ==== btnPeripheralTb.sv ====
`timescale 1ns/1ps

module btnPeripheralTb;

    typedef enum logic [1:0] {opNone, opRead, opWrite} busOp_e;

    typedef struct packed {
        busOp_e     kind;
        logic [3:0] addr;
        logic [3:0] data;
    } busOp_t;

    // one table row, ops run after the hold
    typedef struct packed {
        logic [3:0]       raw;
        logic [3:0]       bounces;
        logic [7:0]       hold;
        busOp_t [3:0]     ops;
    } stimRow_t;

    logic            clk;
    logic            rstN;
    btnPkg::btnVec_t btnRaw;
    btnPkg::busReq_t busReq;
    logic [31:0]     rdata;
    logic            irq;
    int              errorCount;

    stimRow_t    stimTable [15];
    logic [3:0]  lastRaw;
    logic [31:0] rngState;

    btnPeripheral u_dut (
        .clk    (clk),
        .rstN   (rstN),
        .btnRaw (btnRaw),
        .busReq (busReq),
        .rdata  (rdata),
        .irq    (irq)
    );

    btnPeripheralChecker u_check (
        .clk        (clk),
        .rstN       (rstN),
        .btnRaw     (btnRaw),
        .busReq     (busReq),
        .rdata      (rdata),
        .irq        (irq),
        .errorCount (errorCount)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ******************************
    // helpers
    // ******************************

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic busOp_t readOp(input logic [3:0] addr);
        return {opRead, addr, 4'h0};
    endfunction

    function automatic busOp_t writeOp(input logic [3:0] addr, input logic [3:0] data);
        return {opWrite, addr, data};
    endfunction

    function automatic stimRow_t tableRow(input logic [3:0] raw, input logic [3:0] bounces,
                                          input logic [7:0] hold, input busOp_t op0,
                                          input busOp_t op1, input busOp_t op2,
                                          input busOp_t op3);
        return {raw, bounces, hold, op3, op2, op1, op0};  // op0 runs first
    endfunction

    function automatic int runLimitCycles();
        int total;
        total = 100;  // reset and tail
        foreach (stimTable[r]) begin
            total += int'(stimTable[r].hold) + 4;
            total += 2 * int'(stimTable[r].bounces) * btnPkg::debounceCycles;
        end
        return total;
    endfunction

    task automatic waitCycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic runBusOp(input busOp_t op);
        busReq       = '0;
        busReq.addr  = op.addr;
        busReq.wdata = {28'd0, op.data};
        busReq.ren   = (op.kind == opRead);
        busReq.wen   = (op.kind == opWrite);
        @(negedge clk);
        busReq = '0;
    endtask

    task automatic applyRow(input stimRow_t row);
        int len;
        for (int b = 0; b < int'(row.bounces); b++) begin
            rngState = xorshift32(rngState);
            len      = 1 + int'(rngState % (btnPkg::debounceCycles - 1));
            btnRaw   = btnPkg::btnVec_t'(row.raw);
            waitCycles(len);
            rngState = xorshift32(rngState);
            len      = 1 + int'(rngState % (btnPkg::debounceCycles - 1));
            btnRaw   = btnPkg::btnVec_t'(lastRaw);  // bounce back
            waitCycles(len);
        end
        btnRaw  = btnPkg::btnVec_t'(row.raw);
        lastRaw = row.raw;
        waitCycles(int'(row.hold));
        for (int k = 0; k < 4; k++) begin
            if (row.ops[k].kind != opNone) runBusOp(row.ops[k]);
        end
    endtask

    // ******************************
    // main sequence
    // ******************************

    initial begin
        int limit;
        rstN     = 1'b0;
        btnRaw   = '0;
        busReq   = '0;
        lastRaw  = 4'h0;
        rngState = 32'ha324_f221;

        stimTable[0]  = tableRow(4'h0, 0, 2, readOp(0), readOp(1), readOp(2), readOp(3));
        stimTable[1]  = tableRow(4'h8, 0, 20, readOp(0), readOp(1), readOp(2), '0);
        stimTable[2]  = tableRow(4'h0, 0, 20, readOp(0), readOp(2), readOp(1), '0);
        stimTable[3]  = tableRow(4'h4, 0, 8, '0, '0, '0, '0);  // too short
        stimTable[4]  = tableRow(4'h0, 0, 20, readOp(0), readOp(1), '0, '0);
        stimTable[5]  = tableRow(4'h2, 5, 10, '0, '0, '0, '0);  // bouncing, never settles
        stimTable[6]  = tableRow(4'h0, 3, 20, readOp(0), readOp(1), readOp(2), '0);
        stimTable[7]  = tableRow(4'h0, 0, 2, writeOp(1, 8), readOp(1), writeOp(2, 8), readOp(2));
        stimTable[8]  = tableRow(4'h0, 0, 2, writeOp(3, 4'hF), readOp(3), '0, '0);
        stimTable[9]  = tableRow(4'h1, 4, 20, readOp(1), readOp(3), '0, '0);
        stimTable[10] = tableRow(4'h1, 0, 2, writeOp(3, 0), readOp(3), writeOp(3, 1), readOp(1));
        stimTable[11] = tableRow(4'h0, 0, 20, writeOp(1, 1), readOp(1), readOp(2), '0);
        stimTable[12] = tableRow(4'h1, 0, 18, writeOp(1, 1), readOp(1), readOp(0), '0);
        stimTable[13] = tableRow(4'h3, 0, 2, readOp(4), readOp(9), readOp(15), readOp(0));
        stimTable[14] = tableRow(4'h0, 0, 40, readOp(0), readOp(2), writeOp(2, 4'hF), readOp(2));

        limit = runLimitCycles();
        fork
            begin
                #(limit * 100);
                $display("watchdog expired after %0d cycles, stimulus did not finish", limit);
                $display("Test FAILED");
                $finish;
            end
        join_none

        repeat (2) @(negedge clk);
        rstN = 1'b1;
        foreach (stimTable[r]) applyRow(stimTable[r]);
        waitCycles(3);

        $display("checker errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== btnPeripheral.f ====
btnPkg.sv
btnDebounce.sv
btnEventLatch.sv
btnRegFile.sv
btnPeripheral.sv
btnPeripheralChecker.sv
btnPeripheral_asserts.sv
btnPeripheralTb.sv
